//--- source/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// frame format
`define UART_DATA_BITS 8 // data bits per frame
`define UART_PARITY_ODD 0 // 0 even parity, 1 odd parity

// baud timing, one bit lasts CLKS_PER_SAMPLE * SAMPLES_PER_BIT clocks
`define UART_CLKS_PER_SAMPLE 4 // clocks per sample tick
`define UART_SAMPLES_PER_BIT 8 // sample ticks per bit

// receive input
`define UART_SYNC_STAGES 3 // synchronizer depth on the serial input

`endif

//--- source/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

	// transmitter states
	typedef enum logic [1:0] {
		TX_IDLE, // line held high, waiting for start
		TX_WAIT_TICK, // frame loaded, aligning to the bit tick
		TX_SHIFT, // start, data and parity bits on the line
		TX_STOP // stop bit on the line
	} tx_state_e;

	// receiver states
	typedef enum logic [2:0] {
		RX_IDLE, // waiting for a falling edge
		RX_START, // counting to the middle of the start bit
		RX_DATA, // sampling data bits
		RX_PARITY, // sampling the parity bit
		RX_STOP // sampling the stop bit
	} rx_state_e;

	// one received frame with its fault bits
	typedef struct packed {
		logic [`UART_DATA_BITS-1:0] data;
		logic parity_error;
		logic stop_error;
	} rx_frame_t;

endpackage

//--- source/uart_baud_gen.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_baud_gen (
	input logic clk,
	input logic reset,
	output logic o_sample_tick,
	output logic o_bit_tick
);

	localparam int SAMPLE_W = $clog2(`UART_CLKS_PER_SAMPLE);
	localparam int BIT_W = $clog2(`UART_SAMPLES_PER_BIT);

	logic [SAMPLE_W-1:0] sample_cnt; // clocks within one sample period
	logic [BIT_W-1:0] bit_cnt; // sample ticks within one bit period

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_cnt <= '0;
			bit_cnt <= '0;
			o_sample_tick <= 1'b0;
			o_bit_tick <= 1'b0;
		end else begin
			o_sample_tick <= 1'b0;
			o_bit_tick <= 1'b0;
			if (sample_cnt == SAMPLE_W'(`UART_CLKS_PER_SAMPLE - 1)) begin
				sample_cnt <= '0;
				o_sample_tick <= 1'b1;
				if (bit_cnt == BIT_W'(`UART_SAMPLES_PER_BIT - 1)) begin
					bit_cnt <= '0;
					o_bit_tick <= 1'b1; // last sample tick of the bit
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	// the bit tick must line up with a sample tick so tx and rx share one timebase
	a_bit_on_sample: assert property (@(posedge clk) disable iff (reset)
		o_bit_tick |-> o_sample_tick)
		else $error("bit tick without sample tick");

endmodule

//--- source/uart_tx.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_tx (
	input logic clk,
	input logic reset,
	input logic i_tx_start,
	input logic [`UART_DATA_BITS-1:0] i_tx_data,
	input logic i_bit_tick,
	output logic o_serial,
	output logic o_tx_done
);

	localparam int FRAME_BITS = `UART_DATA_BITS + 3; // start, data, parity, stop
	localparam int CNT_W = $clog2(FRAME_BITS);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_BITS - 1);

	uart_pkg::tx_state_e state;
	logic [FRAME_BITS-1:0] shift_reg; // next bit to send in bit 0
	logic [CNT_W-1:0] bit_cnt; // bits already put on the line
	logic parity_bit;

	assign parity_bit = (^i_tx_data) ^ (`UART_PARITY_ODD != 0); // even parity unless odd is set

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			o_serial <= 1'b1; // idle line
			o_tx_done <= 1'b0;
		end else begin
			o_tx_done <= 1'b0;
			case (state)
				uart_pkg::TX_IDLE: begin
					if (i_tx_start) begin
						state <= uart_pkg::TX_WAIT_TICK;
					end
				end
				uart_pkg::TX_WAIT_TICK: begin
					if (i_bit_tick) begin
						o_serial <= shift_reg[0]; // start bit
						bit_cnt <= CNT_W'(1);
						state <= uart_pkg::TX_SHIFT;
					end
				end
				uart_pkg::TX_SHIFT: begin
					if (i_bit_tick) begin
						o_serial <= shift_reg[0];
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT) begin
							state <= uart_pkg::TX_STOP; // stop bit now on the line
						end
					end
				end
				uart_pkg::TX_STOP: begin
					if (i_bit_tick) begin
						o_serial <= 1'b1;
						o_tx_done <= 1'b1; // stop bit has run its full period
						state <= uart_pkg::TX_IDLE;
					end
				end
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE && i_tx_start) begin
			shift_reg <= {1'b1, parity_bit, i_tx_data, 1'b0};
		end else if (i_bit_tick && (state == uart_pkg::TX_WAIT_TICK ||
				state == uart_pkg::TX_SHIFT)) begin
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]}; // lsb first
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (reset)
		state == uart_pkg::TX_IDLE |-> o_serial)
		else $error("serial line low while transmitter idle");

endmodule

//--- source/uart_rx.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_rx (
	input logic clk,
	input logic reset,
	input logic i_serial,
	input logic i_sample_tick,
	output uart_pkg::rx_frame_t o_frame,
	output logic o_frame_strobe
);

	localparam int TICK_W = $clog2(`UART_SAMPLES_PER_BIT);
	localparam int IDX_W = $clog2(`UART_DATA_BITS);
	localparam int BIT_CLKS = `UART_CLKS_PER_SAMPLE * `UART_SAMPLES_PER_BIT; // clocks per bit
	localparam logic [TICK_W-1:0] HALF_BIT = TICK_W'(`UART_SAMPLES_PER_BIT / 2 - 1);
	localparam logic [TICK_W-1:0] FULL_BIT = TICK_W'(`UART_SAMPLES_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_DATA = IDX_W'(`UART_DATA_BITS - 1);

	uart_pkg::rx_state_e state;
	logic [`UART_SYNC_STAGES-1:0] sync; // metastability chain
	logic line; // synchronized serial input
	logic line_d; // previous synchronized value
	logic fall; // start of a possible frame
	logic mid_bit; // sample tick at the middle of a data, parity or stop bit
	logic [TICK_W-1:0] tick_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic [`UART_DATA_BITS-1:0] data_sr;
	logic parity_rx; // parity bit as seen on the line
	logic parity_exp;

	assign line = sync[`UART_SYNC_STAGES-1];
	assign fall = line_d & ~line;
	assign mid_bit = i_sample_tick && (tick_cnt == FULL_BIT);

	// sync chain resets to the idle level so reset does not look like a start bit
	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '1;
			line_d <= 1'b1;
		end else begin
			sync <= {sync[`UART_SYNC_STAGES-2:0], i_serial};
			line_d <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (i_sample_tick) begin
				tick_cnt <= (mid_bit || (state == uart_pkg::RX_START && tick_cnt == HALF_BIT)) ?
					'0 : tick_cnt + 1'b1;
			end
			case (state)
				uart_pkg::RX_IDLE: begin
					tick_cnt <= '0;
					if (fall) begin
						state <= uart_pkg::RX_START;
					end
				end
				uart_pkg::RX_START: begin
					if (i_sample_tick && tick_cnt == HALF_BIT) begin
						bit_idx <= '0;
						// a glitch that is high again at mid start is dropped
						state <= line ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end
				end
				uart_pkg::RX_DATA: begin
					if (mid_bit) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_DATA) begin
							state <= uart_pkg::RX_PARITY;
						end
					end
				end
				uart_pkg::RX_PARITY: begin
					if (mid_bit) begin
						state <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_STOP: begin
					if (mid_bit) begin
						state <= uart_pkg::RX_IDLE;
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && mid_bit) begin
			data_sr <= {line, data_sr[`UART_DATA_BITS-1:1]}; // lsb arrives first
		end
		if (state == uart_pkg::RX_PARITY && mid_bit) begin
			parity_rx <= line;
		end
	end

	assign parity_exp = (^data_sr) ^ (`UART_PARITY_ODD != 0);

	assign o_frame_strobe = (state == uart_pkg::RX_STOP) && mid_bit;
	assign o_frame.data = data_sr;
	assign o_frame.parity_error = parity_rx != parity_exp;
	assign o_frame.stop_error = ~line; // stop bit read low

	// the strobe lands one full bit after the parity bit was sampled
	a_strobe_in_stop: assert property (@(posedge clk) disable iff (reset)
		o_frame_strobe |-> state == uart_pkg::RX_STOP &&
			$past(state, BIT_CLKS) == uart_pkg::RX_PARITY)
		else $error("frame strobe not at the middle of the stop bit");

endmodule

//--- source/uart_ctrl.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_ctrl (
	input logic clk,
	input logic reset,
	input logic i_enable,
	input logic [`UART_DATA_BITS-1:0] i_data,
	input logic i_tx_done,
	input uart_pkg::rx_frame_t i_frame,
	input logic i_frame_strobe,
	output logic o_tx_start,
	output logic [`UART_DATA_BITS-1:0] o_tx_data,
	output logic o_busy,
	output logic [`UART_DATA_BITS-1:0] o_received_data,
	output logic o_data_is_valid,
	output logic o_rx_error
);

	logic accept; // enable strobe taken this cycle

	assign accept = i_enable && !o_busy; // strobes during busy are dropped

	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy <= 1'b0;
			o_tx_start <= 1'b0;
		end else begin
			o_tx_start <= accept;
			if (accept) begin
				o_busy <= 1'b1;
			end else if (i_tx_done) begin
				o_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_tx_data <= i_data;
		end
		if (i_frame_strobe) begin
			o_received_data <= i_frame.data; // newest frame wins
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_data_is_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			o_data_is_valid <= i_frame_strobe;
			if (i_frame_strobe) begin
				o_rx_error <= i_frame.parity_error | i_frame.stop_error;
			end
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		o_data_is_valid |=> !o_data_is_valid)
		else $error("data valid held for two cycles");

	// a start is only issued as busy rises, never while a frame is already going
	a_start_not_busy: assert property (@(posedge clk) disable iff (reset)
		o_tx_start |-> $rose(o_busy))
		else $error("transmit start while busy");

endmodule

//--- source/uart_top.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_top (
	input logic clk,
	input logic reset,
	input logic i_enable,
	input logic [`UART_DATA_BITS-1:0] i_data,
	output logic o_busy,
	output logic o_serial,
	input logic i_serial,
	output logic [`UART_DATA_BITS-1:0] o_received_data,
	output logic o_data_is_valid,
	output logic o_rx_error
);

	logic sample_tick;
	logic bit_tick;
	logic tx_start;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic tx_done;
	uart_pkg::rx_frame_t frame;
	logic frame_strobe;

	uart_ctrl i_uart_ctrl (
		.clk(clk),
		.reset(reset),
		.i_enable(i_enable),
		.i_data(i_data),
		.i_tx_done(tx_done),
		.i_frame(frame),
		.i_frame_strobe(frame_strobe),
		.o_tx_start(tx_start),
		.o_tx_data(tx_data),
		.o_busy(o_busy),
		.o_received_data(o_received_data),
		.o_data_is_valid(o_data_is_valid),
		.o_rx_error(o_rx_error)
	);

	uart_baud_gen i_uart_baud_gen (
		.clk(clk),
		.reset(reset),
		.o_sample_tick(sample_tick),
		.o_bit_tick(bit_tick)
	);

	uart_tx i_uart_tx (
		.clk(clk),
		.reset(reset),
		.i_tx_start(tx_start),
		.i_tx_data(tx_data),
		.i_bit_tick(bit_tick),
		.o_serial(o_serial),
		.o_tx_done(tx_done)
	);

	uart_rx i_uart_rx (
		.clk(clk),
		.reset(reset),
		.i_serial(i_serial),
		.i_sample_tick(sample_tick),
		.o_frame(frame),
		.o_frame_strobe(frame_strobe)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk; // 40 ns period
	end

	initial begin
		o_reset = 1'b1;
		repeat (10) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- tests/uart_tb.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_tb;

	localparam int NUM_TESTS = 10;
	localparam int DW = `UART_DATA_BITS;
	localparam int BIT_CLKS = `UART_CLKS_PER_SAMPLE * `UART_SAMPLES_PER_BIT;
	localparam int W_RESET = 0;
	localparam int W_START = 1;
	localparam int W_IDLE = 2;
	localparam int W_VALID = 3;

	typedef enum logic [1:0] {
		MODE_LOOPBACK,
		MODE_BAD_PARITY,
		MODE_BAD_STOP,
		MODE_BUSY_RETRY
	} mode_e;

	typedef struct packed {
		mode_e mode;
		logic from_lfsr; // byte taken from the lfsr instead of the table
		logic [DW-1:0] data;
	} test_entry_t;

	logic clk;
	logic reset;
	logic enable;
	logic [DW-1:0] data;
	logic busy;
	logic serial_out;
	logic serial_in;
	logic [DW-1:0] received_data;
	logic data_is_valid;
	logic rx_error;
	logic loopback; // receiver fed from the transmitter
	logic tb_line; // serial line driven for injected frames
	test_entry_t tests [NUM_TESTS];
	logic [31:0] lfsr_state = 32'hf74a_9227;
	int valid_count = 0;
	int error_count = 0;
	int tests_run = 0;
	int failed_tests = 0;
	bit timed_out = 1'b0;

	assign serial_in = loopback ? serial_out : tb_line;

	tb_clock i_tb_clock (
		.o_clk(clk),
		.o_reset(reset)
	);

	uart_top i_uart_top (
		.clk(clk),
		.reset(reset),
		.i_enable(enable),
		.i_data(data),
		.o_busy(busy),
		.o_serial(serial_out),
		.i_serial(serial_in),
		.o_received_data(received_data),
		.o_data_is_valid(data_is_valid),
		.o_rx_error(rx_error)
	);

	always @(negedge clk) begin
		if (!reset && data_is_valid) begin
			valid_count <= valid_count + 1;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [DW-1:0] random_byte();
		logic [DW-1:0] b;
		for (int k = 0; k < DW; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b[k] = lfsr_state[0]; // one step per bit
		end
		return b;
	endfunction

	// parity bit that makes the count of ones even and is inverted for odd parity
	function automatic logic parity_of(input logic [DW-1:0] d);
		int ones;
		ones = 0;
		for (int k = 0; k < DW; k++) begin
			ones += d[k];
		end
		return (ones % 2 == 1) ^ (`UART_PARITY_ODD != 0);
	endfunction

	function automatic bit condition_met(input int what, input int since);
		case (what)
			W_RESET: return !reset;
			W_START: return !serial_out;
			W_IDLE: return !busy;
			default: return valid_count != since;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic wait_until(input int what, input int since, input int limit,
			input string desc);
		int n;
		n = 0;
		while (!condition_met(what, since) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!condition_met(what, since)) begin
			$display("timeout: %s within %0d cycles", desc, limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic start_transmit(input logic [DW-1:0] b, input bit retry);
		@(posedge clk);
		enable <= 1'b1;
		data <= b;
		if (retry) begin
			@(posedge clk);
			data <= ~b; // strobe held while busy is dropped
			@(posedge clk);
		end
		@(posedge clk);
		enable <= 1'b0;
		@(negedge clk);
		check_value("o_busy", busy, 1);
	endtask

	// samples o_serial at the middle of each bit
	task automatic check_frame(input logic [DW-1:0] b, input bit retry);
		logic [DW+2:0] frame;
		frame = {1'b1, parity_of(b), b, 1'b0};
		wait_until(W_START, 0, 2 * BIT_CLKS, "no start bit on o_serial");
		if (timed_out) return;
		repeat (BIT_CLKS / 2) @(negedge clk);
		for (int k = 0; k < DW + 3; k++) begin
			if (k > 0) begin
				repeat (BIT_CLKS) @(negedge clk);
			end
			check_value($sformatf("o_serial bit %0d", k), serial_out, frame[k]);
			check_value("o_busy", busy, 1);
		end
		if (retry) begin
			// one strobe in the last busy cycle while the transmitter is idle again
			repeat (BIT_CLKS / 2) @(posedge clk);
			enable <= 1'b1;
			data <= ~b;
			@(posedge clk);
			enable <= 1'b0;
			@(negedge clk);
		end
		wait_until(W_IDLE, 0, BIT_CLKS, "o_busy did not fall after the stop bit");
	endtask

	task automatic inject_frame(input logic [DW-1:0] b, input bit bad_parity,
			input bit bad_stop);
		logic [DW+2:0] frame;
		frame = {~bad_stop, parity_of(b) ^ bad_parity, b, 1'b0};
		for (int k = 0; k < DW + 3; k++) begin
			@(posedge clk);
			tb_line <= frame[k];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		tb_line <= 1'b1;
	endtask

	task automatic run_test(input int idx);
		test_entry_t t;
		int errors_before;
		int valids_before;
		bit bad_frame;
		t = tests[idx];
		if (t.from_lfsr) begin
			t.data = random_byte();
		end
		bad_frame = (t.mode == MODE_BAD_PARITY || t.mode == MODE_BAD_STOP);
		errors_before = error_count;
		valids_before = valid_count;
		tests_run++;
		@(posedge clk);
		loopback <= !bad_frame;
		if (bad_frame) begin
			inject_frame(t.data, t.mode == MODE_BAD_PARITY, t.mode == MODE_BAD_STOP);
		end else begin
			start_transmit(t.data, t.mode == MODE_BUSY_RETRY);
			check_frame(t.data, t.mode == MODE_BUSY_RETRY);
		end
		if (!timed_out) begin
			wait_until(W_VALID, valids_before, 4 * BIT_CLKS, "no valid pulse from the receiver");
		end
		if (!timed_out) begin
			check_value("o_received_data", received_data, t.data);
			check_value("o_rx_error", rx_error, bad_frame);
			repeat (BIT_CLKS) @(negedge clk); // a second pulse would show up in this quiet time
			check_value("valid pulse count", valid_count - valids_before, 1);
		end
		if (error_count == errors_before && !timed_out) begin
			$display("test %0d %s data %h ok", idx, t.mode.name(), t.data);
		end else begin
			failed_tests++;
			$display("test %0d %s data %h failed", idx, t.mode.name(), t.data);
		end
	endtask

	initial begin
		enable = 1'b0;
		data = '0;
		loopback = 1'b1;
		tb_line = 1'b1;
		tests[0] = '{MODE_LOOPBACK, 1'b0, 8'h00};
		tests[1] = '{MODE_LOOPBACK, 1'b0, 8'hff};
		tests[2] = '{MODE_LOOPBACK, 1'b0, 8'ha5};
		tests[3] = '{MODE_LOOPBACK, 1'b1, 8'h00};
		tests[4] = '{MODE_LOOPBACK, 1'b1, 8'h00};
		tests[5] = '{MODE_BUSY_RETRY, 1'b0, 8'h3c};
		tests[6] = '{MODE_BAD_PARITY, 1'b0, 8'h5a};
		tests[7] = '{MODE_BAD_STOP, 1'b0, 8'h96};
		tests[8] = '{MODE_LOOPBACK, 1'b1, 8'h00}; // must clear the error flag again
		tests[9] = '{MODE_BAD_PARITY, 1'b1, 8'h00};
		@(negedge clk);
		wait_until(W_RESET, 0, 20, "reset was not released");
		if (!timed_out) begin
			tests_run++;
			check_value("o_serial", serial_out, 1);
			check_value("o_busy", busy, 0);
			check_value("o_data_is_valid", data_is_valid, 0);
			check_value("o_rx_error", rx_error, 0);
			if (error_count == 0) begin
				$display("test reset values ok");
			end else begin
				failed_tests++;
				$display("test reset values failed");
			end
		end
		for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
			run_test(i);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_ctrl.sv
source/uart_top.sv
tests/tb_clock.sv
tests/uart_tb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - include_dirs:
      - source
    files:
      - source/uart_pkg.sv
      - source/uart_baud_gen.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_ctrl.sv
      - source/uart_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_clock.sv
      - tests/uart_tb.sv
